// File: hdl/lsu_pkg.sv
// load/store unit shared definitions
// data word geometry, access size and fill mode encodings,
// and the request/response controller states
package lsu_pkg;

  ////////////////////////////////////////
  // word geometry
  ////////////////////////////////////////
  parameter int DATA_WIDTH   = 32;             // data word width
  parameter int BE_WIDTH     = DATA_WIDTH / 8; // one enable per byte lane
  parameter int OFFSET_WIDTH = 2;              // byte offset inside a word

  ////////////////////////////////////////
  // encodings from the EX stage
  ////////////////////////////////////////

  // access size, 2'b11 behaves as a byte
  typedef enum logic [1:0] {
    TYPE_WORD = 2'b00,
    TYPE_HALF = 2'b01,
    TYPE_BYTE = 2'b10
  } lsu_type_e;

  // fill of the upper bits on narrow loads, 2'b11 behaves as sign
  typedef enum logic [1:0] {
    SEXT_ZERO = 2'b00,  // zero extend
    SEXT_SIGN = 2'b01,  // copy the sign bit
    SEXT_ONES = 2'b10   // fill with ones
  } lsu_sext_e;

  // controller states
  typedef enum logic [1:0] {
    LSU_IDLE,                  // nothing outstanding
    LSU_WAIT_RVALID,           // granted, waiting for the response
    LSU_WAIT_RVALID_EX_STALL,  // granted while EX was stalled
    LSU_IDLE_EX_STALL          // response in, EX still stalled
  } lsu_state_e;

endpackage

// File: hdl/lsu_store_align.sv
// store-side shaping of a memory request
// builds the byte enables for word, halfword and byte accesses,
// rotates the register data onto the addressed lanes and flags
// accesses that need a second memory access
`timescale 1ns/1ps

module lsu_store_align
(
  input  lsu_pkg::lsu_type_e               data_type_i,    // access size
  input  logic [lsu_pkg::OFFSET_WIDTH-1:0] addr_offset_i,  // low address bits
  input  logic [lsu_pkg::OFFSET_WIDTH-1:0] reg_offset_i,   // byte position in the register
  input  logic [lsu_pkg::DATA_WIDTH-1:0]   wdata_i,        // register data
  input  logic                             req_i,          // EX wants an access
  input  logic                             misaligned_ex_i, // second part of a split access

  output logic [lsu_pkg::BE_WIDTH-1:0]     be_o,
  output logic [lsu_pkg::DATA_WIDTH-1:0]   wdata_o,
  output logic                             misaligned_o
);

  logic [lsu_pkg::OFFSET_WIDTH-1:0] wdata_offset;  // lane rotation amount

  ////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////
  always_comb
  begin
    case (data_type_i)
      lsu_pkg::TYPE_WORD:
      begin
        if (!misaligned_ex_i)
          be_o = 4'b1111 << addr_offset_i;     // offset up to the word end
        else
          be_o = ~(4'b1111 << addr_offset_i);  // lanes below the offset, none at 0
      end

      lsu_pkg::TYPE_HALF:
      begin
        if (!misaligned_ex_i)
          be_o = 4'b0011 << addr_offset_i;     // upper lane drops off at offset 3
        else
          be_o = 4'b0001;                      // spill into lane 0 of the next word
      end

      default:
        be_o = 4'b0001 << addr_offset_i;       // single lane, 2'b11 lands here too
    endcase
  end

  ////////////////////////////////////////
  // store data rotation
  ////////////////////////////////////////

  // register byte reg_offset_i has to end up on lane addr_offset_i
  assign wdata_offset = addr_offset_i - reg_offset_i;  // wraps modulo 4

  always_comb
  begin
    case (wdata_offset)
      2'b00:   wdata_o = wdata_i;
      2'b01:   wdata_o = {wdata_i[23:0], wdata_i[31:24]};  // one lane up
      2'b10:   wdata_o = {wdata_i[15:0], wdata_i[31:16]};  // swap halves
      default: wdata_o = {wdata_i[7:0],  wdata_i[31:8]};   // three lanes up
    endcase
  end

  ////////////////////////////////////////
  // misaligned access detection
  ////////////////////////////////////////

  // only the first part is checked, the second part is already known
  always_comb
  begin
    misaligned_o = 1'b0;
    if (req_i && !misaligned_ex_i)
    begin
      if (data_type_i == lsu_pkg::TYPE_WORD && addr_offset_i != 2'b00)
        misaligned_o = 1'b1;  // word crosses into the next word
      if (data_type_i == lsu_pkg::TYPE_HALF && addr_offset_i == 2'b11)
        misaligned_o = 1'b1;  // halfword straddles the boundary
    end
  end

endmodule

// File: hdl/lsu_load_align.sv
// load-side alignment and extension
// keeps the attributes of the granted access until its response,
// picks the addressed byte or halfword out of the returned word,
// fills the upper bits per the requested mode and reassembles
// misaligned words and halfwords from two responses
`timescale 1ns/1ps

module lsu_load_align
(
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             gnt_i,            // request accepted by memory
  input  logic                             rvalid_i,         // response valid
  input  lsu_pkg::lsu_type_e               type_i,
  input  lsu_pkg::lsu_sext_e               sign_ext_i,
  input  logic [lsu_pkg::OFFSET_WIDTH-1:0] addr_offset_i,
  input  logic                             we_i,
  input  logic                             misaligned_ex_i,  // EX is in the second part
  input  logic                             misaligned_i,     // first part just detected
  input  logic [lsu_pkg::DATA_WIDTH-1:0]   rdata_i,
  output logic [lsu_pkg::DATA_WIDTH-1:0]   rdata_o
);

  // attributes of the access in flight
  lsu_pkg::lsu_type_e               type_q;
  lsu_pkg::lsu_sext_e               sext_q;
  logic [lsu_pkg::OFFSET_WIDTH-1:0] offset_q;
  logic                             we_q;

  logic [lsu_pkg::DATA_WIDTH-1:0]   rdata_q;      // last result or raw first word

  logic [lsu_pkg::DATA_WIDTH-1:0]   rdata_w_ext;  // word, only reassembly
  logic [15:0]                      half_raw;
  logic [lsu_pkg::DATA_WIDTH-1:0]   rdata_h_ext;
  logic [7:0]                       byte_raw;
  logic [lsu_pkg::DATA_WIDTH-1:0]   rdata_b_ext;
  logic [lsu_pkg::DATA_WIDTH-1:0]   rdata_ext;

  // sample at grant, response comes back at least one cycle later
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      type_q   <= lsu_pkg::TYPE_WORD;
      sext_q   <= lsu_pkg::SEXT_ZERO;
      offset_q <= '0;
      we_q     <= 1'b0;
    end
    else if (gnt_i)
    begin
      type_q   <= type_i;
      sext_q   <= sign_ext_i;
      offset_q <= addr_offset_i;
      we_q     <= we_i;
    end
  end

  ////////////////////////////////////////
  // lane extraction
  ////////////////////////////////////////

  // new low bytes go above the stored high bytes of the first word
  always_comb
  begin
    case (offset_q)
      2'b00:   rdata_w_ext = rdata_i;
      2'b01:   rdata_w_ext = {rdata_i[7:0],  rdata_q[31:8]};
      2'b10:   rdata_w_ext = {rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w_ext = {rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb
  begin
    case (offset_q)
      2'b00:   half_raw = rdata_i[15:0];
      2'b01:   half_raw = rdata_i[23:8];
      2'b10:   half_raw = rdata_i[31:16];
      default: half_raw = {rdata_i[7:0], rdata_q[31:24]};  // split halfword
    endcase
  end

  assign byte_raw = rdata_i[{offset_q, 3'b000} +: 8];

  ////////////////////////////////////////
  // upper bit fill
  ////////////////////////////////////////
  always_comb
  begin
    case (sext_q)
      lsu_pkg::SEXT_ZERO:
      begin
        rdata_h_ext = {16'h0000, half_raw};
        rdata_b_ext = {24'h00_0000, byte_raw};
      end
      lsu_pkg::SEXT_ONES:
      begin
        rdata_h_ext = {16'hffff, half_raw};
        rdata_b_ext = {24'hff_ffff, byte_raw};
      end
      default:
      begin  // sign copy, also for 2'b11
        rdata_h_ext = {{16{half_raw[15]}}, half_raw};
        rdata_b_ext = {{24{byte_raw[7]}}, byte_raw};
      end
    endcase
  end

  always_comb
  begin
    case (type_q)
      lsu_pkg::TYPE_WORD: rdata_ext = rdata_w_ext;
      lsu_pkg::TYPE_HALF: rdata_ext = rdata_h_ext;
      default:            rdata_ext = rdata_b_ext;  // byte and 2'b11
    endcase
  end

  // raw word kept while a split access is running, result otherwise
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (rvalid_i && !we_q)
      rdata_q <= (misaligned_ex_i || misaligned_i) ? rdata_i : rdata_ext;
  end

  assign rdata_o = rvalid_i ? rdata_ext : rdata_q;  // bypass in the response cycle

endmodule

// File: hdl/lsu_ctrl_fsm.sv
// request/response controller of the load/store unit
// forwards EX requests to memory, tracks the outstanding response
// and produces the EX and WB ready strobes and the busy flag
`timescale 1ns/1ps

module lsu_ctrl_fsm
(
  input  logic clk,
  input  logic rst_n,
  input  logic req_i,       // request from EX
  input  logic gnt_i,       // memory grant
  input  logic rvalid_i,    // memory response
  input  logic err_i,       // bus error, only releases EX
  input  logic ex_valid_i,  // EX stage completes this cycle

  output logic data_req_o,
  output logic ready_ex_o,
  output logic ready_wb_o,
  output logic busy_o
);

  lsu_pkg::lsu_state_e state_q, state_d;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= lsu_pkg::LSU_IDLE;
    else
      state_q <= state_d;
  end

  ////////////////////////////////////////
  // next state and strobes
  ////////////////////////////////////////
  always_comb
  begin
    state_d    = state_q;
    data_req_o = 1'b0;
    ready_ex_o = 1'b1;
    ready_wb_o = 1'b1;

    case (state_q)
      lsu_pkg::LSU_IDLE:
      begin
        data_req_o = req_i;        // straight through
        if (req_i)
        begin
          ready_ex_o = gnt_i || err_i;  // hold EX until accepted
          if (gnt_i)
            state_d = ex_valid_i ? lsu_pkg::LSU_WAIT_RVALID
                                 : lsu_pkg::LSU_WAIT_RVALID_EX_STALL;
        end
      end

      lsu_pkg::LSU_WAIT_RVALID:
      begin
        ready_wb_o = rvalid_i;     // WB stalls only on us
        if (rvalid_i)
        begin
          data_req_o = req_i;      // next request overlaps the response
          if (req_i)
          begin
            ready_ex_o = gnt_i || err_i;
            if (gnt_i)
              state_d = ex_valid_i ? lsu_pkg::LSU_WAIT_RVALID
                                   : lsu_pkg::LSU_WAIT_RVALID_EX_STALL;
            else
              state_d = lsu_pkg::LSU_IDLE;  // retry from idle
          end
          else
            state_d = lsu_pkg::LSU_IDLE;
        end
      end

      // granted under an EX stall, no new request goes out here
      lsu_pkg::LSU_WAIT_RVALID_EX_STALL:
      begin
        if (rvalid_i)
          state_d = ex_valid_i ? lsu_pkg::LSU_IDLE : lsu_pkg::LSU_IDLE_EX_STALL;
        else if (ex_valid_i)
          state_d = lsu_pkg::LSU_WAIT_RVALID;  // stall gone, normal wait
      end

      lsu_pkg::LSU_IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = lsu_pkg::LSU_IDLE;
      end

      default: state_d = lsu_pkg::LSU_IDLE;
    endcase
  end

  assign busy_o = (state_q != lsu_pkg::LSU_IDLE) || data_req_o;

endmodule

// File: hdl/load_store_unit.sv
// load/store unit of a small 32-bit RISC-V style core
// generates the data address, shapes store requests, aligns and
// extends load data and sequences requests against the
// request/grant and response-valid memory interface
`timescale 1ns/1ps

module load_store_unit
#(
  parameter int ADDR_WIDTH = 32
)
(
  input  logic                             clk,
  input  logic                             rst_n,

  // memory side
  output logic                             data_req_o,
  output logic [ADDR_WIDTH-1:0]            data_addr_o,
  output logic                             data_we_o,
  output logic [lsu_pkg::BE_WIDTH-1:0]     data_be_o,
  output logic [lsu_pkg::DATA_WIDTH-1:0]   data_wdata_o,
  input  logic                             data_gnt_i,
  input  logic                             data_rvalid_i,
  input  logic                             data_err_i,
  input  logic [lsu_pkg::DATA_WIDTH-1:0]   data_rdata_i,

  // EX stage, held until granted
  input  logic                             data_req_ex_i,
  input  logic                             data_we_ex_i,
  input  lsu_pkg::lsu_type_e               data_type_ex_i,
  input  lsu_pkg::lsu_sext_e               data_sign_ext_ex_i,
  input  logic [lsu_pkg::DATA_WIDTH-1:0]   data_wdata_ex_i,
  input  logic [lsu_pkg::OFFSET_WIDTH-1:0] data_reg_offset_ex_i,
  input  logic [ADDR_WIDTH-1:0]            operand_a_ex_i,
  input  logic [ADDR_WIDTH-1:0]            operand_b_ex_i,
  input  logic                             addr_useincr_ex_i,  // a + b instead of a
  input  logic                             data_misaligned_ex_i,
  input  logic                             ex_valid_i,

  output logic [lsu_pkg::DATA_WIDTH-1:0]   data_rdata_ex_o,
  output logic                             data_misaligned_o,
  output logic                             lsu_ready_ex_o,
  output logic                             lsu_ready_wb_o,
  output logic                             busy_o
);

  logic [ADDR_WIDTH-1:0]            data_addr_int;
  logic [lsu_pkg::OFFSET_WIDTH-1:0] addr_offset;  // byte lane of the access

  assign data_addr_int = addr_useincr_ex_i ? (operand_a_ex_i + operand_b_ex_i)
                                           : operand_a_ex_i;
  assign addr_offset   = data_addr_int[lsu_pkg::OFFSET_WIDTH-1:0];

  assign data_addr_o   = data_addr_int;
  assign data_we_o     = data_we_ex_i;

  lsu_store_align i_store_align (
    .data_type_i     (data_type_ex_i),
    .addr_offset_i   (addr_offset),
    .reg_offset_i    (data_reg_offset_ex_i),
    .wdata_i         (data_wdata_ex_i),
    .req_i           (data_req_ex_i),
    .misaligned_ex_i (data_misaligned_ex_i),
    .be_o            (data_be_o),
    .wdata_o         (data_wdata_o),
    .misaligned_o    (data_misaligned_o)
  );

  lsu_load_align i_load_align (
    .clk             (clk),
    .rst_n           (rst_n),
    .gnt_i           (data_gnt_i),
    .rvalid_i        (data_rvalid_i),
    .type_i          (data_type_ex_i),
    .sign_ext_i      (data_sign_ext_ex_i),
    .addr_offset_i   (addr_offset),
    .we_i            (data_we_ex_i),
    .misaligned_ex_i (data_misaligned_ex_i),
    .misaligned_i    (data_misaligned_o),
    .rdata_i         (data_rdata_i),
    .rdata_o         (data_rdata_ex_o)
  );

  lsu_ctrl_fsm i_ctrl_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (data_req_ex_i),
    .gnt_i      (data_gnt_i),
    .rvalid_i   (data_rvalid_i),
    .err_i      (data_err_i),
    .ex_valid_i (ex_valid_i),
    .data_req_o (data_req_o),
    .ready_ex_o (lsu_ready_ex_o),
    .ready_wb_o (lsu_ready_wb_o),
    .busy_o     (busy_o)
  );

endmodule

// File: test/tb_load_store_unit.sv
// testbench for the load/store unit
// a memory responder grants every request at once and answers one
// cycle later, directed tests cover store lanes, narrow and split
// loads, overlapped requests and the EX stall path
`timescale 1ns/1ps

module tb_load_store_unit;

  localparam int TMO = 20;  // cycles any single wait may take

  logic        clk;
  logic        rst_n;
  logic        data_req_o;
  logic [31:0] data_addr_o;
  logic        data_we_o;
  logic [3:0]  data_be_o;
  logic [31:0] data_wdata_o;
  wire         data_gnt_i;
  logic        data_rvalid_i;
  logic        data_err_i;
  logic [31:0] data_rdata_i;
  logic        data_req_ex_i;
  logic        data_we_ex_i;
  lsu_pkg::lsu_type_e data_type_ex_i;
  lsu_pkg::lsu_sext_e data_sign_ext_ex_i;
  logic [31:0] data_wdata_ex_i;
  logic [1:0]  data_reg_offset_ex_i;
  logic [31:0] operand_a_ex_i;
  logic [31:0] operand_b_ex_i;
  logic        addr_useincr_ex_i;
  logic        data_misaligned_ex_i;
  logic        ex_valid_i;
  logic [31:0] data_rdata_ex_o;
  logic        data_misaligned_o;
  logic        lsu_ready_ex_o;
  logic        lsu_ready_wb_o;
  logic        busy_o;

  logic [31:0] mem [0:15];  // responder storage, word addressed
  integer      seed;
  integer      checks;
  integer      errors;

  load_store_unit #(.ADDR_WIDTH(32)) UUT (
    .clk (clk), .rst_n (rst_n),
    .data_req_o (data_req_o), .data_addr_o (data_addr_o), .data_we_o (data_we_o),
    .data_be_o (data_be_o), .data_wdata_o (data_wdata_o),
    .data_gnt_i (data_gnt_i), .data_rvalid_i (data_rvalid_i), .data_err_i (data_err_i),
    .data_rdata_i (data_rdata_i),
    .data_req_ex_i (data_req_ex_i), .data_we_ex_i (data_we_ex_i),
    .data_type_ex_i (data_type_ex_i), .data_sign_ext_ex_i (data_sign_ext_ex_i),
    .data_wdata_ex_i (data_wdata_ex_i), .data_reg_offset_ex_i (data_reg_offset_ex_i),
    .operand_a_ex_i (operand_a_ex_i), .operand_b_ex_i (operand_b_ex_i),
    .addr_useincr_ex_i (addr_useincr_ex_i), .data_misaligned_ex_i (data_misaligned_ex_i),
    .ex_valid_i (ex_valid_i),
    .data_rdata_ex_o (data_rdata_ex_o), .data_misaligned_o (data_misaligned_o),
    .lsu_ready_ex_o (lsu_ready_ex_o), .lsu_ready_wb_o (lsu_ready_wb_o), .busy_o (busy_o)
  );

  always #10 clk = ~clk;  // 20 ns period

  ////////////////////////////////////////
  // memory responder
  ////////////////////////////////////////
  assign data_gnt_i = data_req_o;  // grant in the request cycle

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_rvalid_i <= 1'b0;
      data_rdata_i  <= '0;
    end
    else
    begin
      data_rvalid_i <= data_req_o && data_gnt_i;  // answer one cycle later
      if (data_req_o && data_gnt_i && !data_we_o)
        data_rdata_i <= mem[data_addr_o[5:2]];    // low bits ignored
    end
  end

  ////////////////////////////////////////
  // expected values
  ////////////////////////////////////////
  function automatic logic [3:0] exp_be(input logic [1:0] t, input logic [1:0] off,
                                        input logic second);
    integer lane;
    integer size;
    begin
      size = (t == 2'd0) ? 4 : (t == 2'd1) ? 2 : 1;
      for (lane = 0; lane < 4; lane++)
        if (!second)
          exp_be[lane] = (lane >= off) && (lane < off + size);  // clipped at word end
        else if (t == 2'd0)
          exp_be[lane] = lane < off;
        else
          exp_be[lane] = (lane == 0);
    end
  endfunction

  // register byte k lands on lane k + (addr offset - reg offset)
  function automatic logic [31:0] exp_wdata(input logic [31:0] wd, input logic [1:0] off,
                                            input logic [1:0] roff);
    integer     k;
    logic [1:0] lane;
    begin
      for (k = 0; k < 4; k++)
      begin
        lane = k + off - roff;  // wraps mod 4
        exp_wdata[lane*8 +: 8] = wd[k*8 +: 8];
      end
    end
  endfunction

  // bytes from the offset upward across lo then hi, filled per mode
  function automatic logic [31:0] exp_load(input logic [31:0] hi, input logic [31:0] lo,
                                           input logic [1:0] t, input logic [1:0] s,
                                           input logic [1:0] off);
    logic [63:0] both;
    logic [31:0] raw;
    logic        fill;
    begin
      both = {hi, lo} >> (8 * off);
      raw  = both[31:0];
      if (s == 2'd2)
        fill = 1'b1;
      else if (s == 2'd0)
        fill = 1'b0;
      else
        fill = (t == 2'd1) ? raw[15] : raw[7];  // sign, also for 2'b11
      if (t == 2'd0)
        exp_load = raw;
      else if (t == 2'd1)
        exp_load = {{16{fill}}, raw[15:0]};
      else
        exp_load = {{24{fill}}, raw[7:0]};
    end
  endfunction

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  task compare(input logic [31:0] got, input logic [31:0] exp, input string what);
    begin
      checks = checks + 1;
      if (got !== exp)
      begin
        errors = errors + 1;
        $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
    end
  endtask

  task abort_on_timeout(input string what);
    begin
      $display("timeout at %0t ns: %s", $time, what);
      $display("CHECKS FAILED");
      $finish;
    end
  endtask

  task finish_test(input string name, input integer e0);
    $display("%-24s done, %0d errors", name, errors - e0);
  endtask

  task wait_grant;
    integer n;
    begin
      n = 0;
      #2;
      while (!(data_req_o && data_gnt_i) && n < TMO)
      begin
        @(negedge clk);
        #2;
        n = n + 1;
      end
      if (n >= TMO)
        abort_on_timeout("the request was never granted");
    end
  endtask

  task wait_rvalid;
    integer n;
    begin
      n = 0;
      #2;
      while (!data_rvalid_i && n < TMO)
      begin
        @(negedge clk);
        #2;
        n = n + 1;
      end
      if (n >= TMO)
        abort_on_timeout("no read response arrived");
    end
  endtask

  task drive_access(input logic we, input logic [1:0] t, input logic [1:0] s,
                    input logic [31:0] a, input logic [31:0] b, input logic incr,
                    input logic [31:0] wd, input logic [1:0] roff, input logic mis);
    begin
      data_req_ex_i        = 1'b1;
      data_we_ex_i         = we;
      data_type_ex_i       = lsu_pkg::lsu_type_e'(t);
      data_sign_ext_ex_i   = lsu_pkg::lsu_sext_e'(s);
      operand_a_ex_i       = a;
      operand_b_ex_i       = b;
      addr_useincr_ex_i    = incr;
      data_wdata_ex_i      = wd;
      data_reg_offset_ex_i = roff;
      data_misaligned_ex_i = mis;
    end
  endtask

  // single load through the adder, result checked twice
  task load_once(input logic [1:0] t, input logic [1:0] s, input logic [3:0] idx,
                 input logic [1:0] off);
    logic [31:0] exp;
    begin
      exp = exp_load(mem[idx + 4'd1], mem[idx], t, s, off);
      @(negedge clk);
      drive_access(1'b0, t, s, {26'd0, idx, 2'b00}, {30'd0, off}, 1'b1, '0, 2'd0, 1'b0);
      wait_grant;
      compare(data_addr_o, {26'd0, idx, off}, "load address a + b");
      @(negedge clk);
      data_req_ex_i = 1'b0;
      wait_rvalid;
      compare(data_rdata_ex_o, exp, "load result in response cycle");
      @(negedge clk);
      #2;
      compare(data_rdata_ex_o, exp, "load result one cycle later");
    end
  endtask

  // first part, then second part overlapping the first response
  task split_once(input logic [1:0] t, input logic [1:0] s, input logic [3:0] idx,
                  input logic [1:0] off);
    logic [31:0] exp;
    begin
      exp = exp_load(mem[idx + 4'd1], mem[idx], t, s, off);
      @(negedge clk);
      drive_access(1'b0, t, s, {26'd0, idx, off}, '0, 1'b0, '0, 2'd0, 1'b0);
      #2;
      compare(data_misaligned_o, 1'b1, "first part flagged as misaligned");
      wait_grant;
      @(negedge clk);
      operand_a_ex_i       = {26'd0, idx, off} + 32'd4;  // next word
      data_misaligned_ex_i = 1'b1;
      wait_rvalid;
      compare(data_be_o, exp_be(t, off, 1'b1), "second part byte enables");
      compare(data_misaligned_o, 1'b0, "second part not flagged");
      wait_grant;
      @(negedge clk);
      data_req_ex_i        = 1'b0;
      data_misaligned_ex_i = 1'b0;
      wait_rvalid;
      compare(data_rdata_ex_o, exp, "reassembled load result");
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task reset_state_test;
    integer e0;
    begin
      e0 = errors;
      @(negedge clk);
      #2;
      compare(data_req_o, 1'b0, "no request after reset");
      compare(busy_o, 1'b0, "not busy after reset");
      compare(lsu_ready_ex_o, 1'b1, "EX ready after reset");
      compare(lsu_ready_wb_o, 1'b1, "WB ready after reset");
      finish_test("reset state", e0);
    end
  endtask

  task store_lanes_test;
    integer      e0;
    integer      t;
    integer      sec;
    integer      off;
    integer      r;
    logic [31:0] wd;
    logic        exp_mis;
    begin
      e0 = errors;
      for (t = 0; t < 3; t++)
        for (sec = 0; sec < 2; sec++)
          for (off = 0; off < 4; off++)
            for (r = 0; r < 4; r++)
              if (!(sec == 1 && t == 2))  // bytes never split
              begin
                wd      = $random(seed);
                exp_mis = (sec == 0) && ((t == 0 && off != 0) || (t == 1 && off == 3));
                @(negedge clk);
                drive_access(1'b1, t[1:0], 2'd0, 32'h20 + off, '0, 1'b0, wd, r[1:0], sec[0]);
                #2;
                compare(data_be_o, exp_be(t[1:0], off[1:0], sec[0]), "store byte enables");
                compare(data_wdata_o, exp_wdata(wd, off[1:0], r[1:0]), "store data lanes");
                compare(data_misaligned_o, exp_mis, "misaligned detection");
                compare(data_we_o, 1'b1, "write enable");
                wait_grant;
                @(negedge clk);
                data_req_ex_i        = 1'b0;
                data_misaligned_ex_i = 1'b0;
                wait_rvalid;
              end
      finish_test("stores at every offset", e0);
    end
  endtask

  task narrow_load_test;
    integer     e0;
    integer     t;
    integer     off;
    integer     s;
    logic [3:0] idx;
    begin
      e0 = errors;
      for (t = 1; t < 3; t++)
        for (off = 0; off < 4; off++)
          for (s = 0; s < 3; s++)
            if (!(t == 1 && off == 3))  // split halfword is covered below
            begin
              idx = $unsigned($random(seed)) % 15;
              load_once(t[1:0], s[1:0], idx, off[1:0]);
            end
      finish_test("narrow loads", e0);
    end
  endtask

  task split_load_test;
    integer e0;
    integer k;
    begin
      e0 = errors;
      for (k = 1; k < 4; k++)
        split_once(2'd0, 2'd0, 4'(2 + 3 * k), k[1:0]);  // word at offsets 1..3
      for (k = 0; k < 3; k++)
        split_once(2'd1, k[1:0], 4'(4 * k + 1), 2'd3);  // halfword across the boundary
      finish_test("misaligned loads", e0);
    end
  endtask

  task back_to_back_test;
    integer      e0;
    logic [31:0] exp0;
    logic [31:0] exp1;
    begin
      e0   = errors;
      exp0 = exp_load(mem[4], mem[3], 2'd0, 2'd0, 2'd0);
      exp1 = exp_load(mem[10], mem[9], 2'd2, 2'd1, 2'd2);
      @(negedge clk);
      drive_access(1'b0, 2'd0, 2'd0, 32'd12, '0, 1'b0, '0, 2'd0, 1'b0);
      wait_grant;
      @(negedge clk);
      drive_access(1'b0, 2'd2, 2'd1, 32'd38, '0, 1'b0, '0, 2'd0, 1'b0);
      wait_rvalid;
      compare(data_req_o, 1'b1, "second request driven in response cycle");
      compare(data_rdata_ex_o, exp0, "first result");
      wait_grant;
      @(negedge clk);
      data_req_ex_i = 1'b0;
      wait_rvalid;
      compare(data_rdata_ex_o, exp1, "second result");
      finish_test("back-to-back loads", e0);
    end
  endtask

  task ex_stall_test;
    integer      e0;
    logic [31:0] exp0;
    logic [31:0] exp1;
    begin
      e0   = errors;
      exp0 = mem[5];
      exp1 = mem[6];
      @(negedge clk);
      ex_valid_i = 1'b0;  // EX stalled at the grant
      drive_access(1'b0, 2'd0, 2'd0, 32'd20, '0, 1'b0, '0, 2'd0, 1'b0);
      wait_grant;
      @(negedge clk);
      operand_a_ex_i = 32'd24;  // next request already waiting
      wait_rvalid;
      compare(data_req_o, 1'b0, "request held during stalled wait");
      compare(busy_o, 1'b1, "busy during stalled wait");
      compare(data_rdata_ex_o, exp0, "stalled load result");
      @(negedge clk);
      #2;
      compare(data_req_o, 1'b0, "request held after response");
      compare(busy_o, 1'b1, "busy until EX resumes");
      @(negedge clk);
      ex_valid_i = 1'b1;
      wait_grant;  // goes out once the stall state is left
      @(negedge clk);
      data_req_ex_i = 1'b0;
      wait_rvalid;
      compare(data_rdata_ex_o, exp1, "load after the stall");
      @(negedge clk);
      #2;
      compare(busy_o, 1'b0, "idle after the stall");
      finish_test("EX stall", e0);
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial
  begin : main
    integer i;
    seed                 = 76;
    checks               = 0;
    errors               = 0;
    clk                  = 1'b0;
    rst_n                = 1'b0;
    data_err_i           = 1'b0;
    data_req_ex_i        = 1'b0;
    data_we_ex_i         = 1'b0;
    data_type_ex_i       = lsu_pkg::TYPE_WORD;
    data_sign_ext_ex_i   = lsu_pkg::SEXT_ZERO;
    data_wdata_ex_i      = '0;
    data_reg_offset_ex_i = '0;
    operand_a_ex_i       = '0;
    operand_b_ex_i       = '0;
    addr_useincr_ex_i    = 1'b0;
    data_misaligned_ex_i = 1'b0;
    ex_valid_i           = 1'b1;
    for (i = 0; i < 16; i++)
      mem[i] = $random(seed);
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    reset_state_test;
    store_lanes_test;
    narrow_load_test;
    split_load_test;
    back_to_back_test;
    ex_stall_test;

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: flist.f
hdl/lsu_pkg.sv
hdl/lsu_store_align.sv
hdl/lsu_load_align.sv
hdl/lsu_ctrl_fsm.sv
hdl/load_store_unit.sv
test/tb_load_store_unit.sv

// File: Bender.yml
package:
  name: load_store_unit

sources:
  - hdl/lsu_pkg.sv
  - hdl/lsu_store_align.sv
  - hdl/lsu_load_align.sv
  - hdl/lsu_ctrl_fsm.sv
  - hdl/load_store_unit.sv
  - target: test
    files:
      - test/tb_load_store_unit.sv
